//--- list.f
+incdir+common
common/capture_pkg.sv
common/bus_pkg.sv
hw/sampler/sample_writer.sv
hw/pingpong/pingpong_ram.sv
hw/bus_slave/wb_readout.sv
hw/scope_capture_top.sv
dv/scope_capture_asserts.sv
dv/scope_capture_tb.sv

//--- Makefile
VERILATOR  ?= verilator
TOP        := scope_capture_tb
FILELIST   := list.f
BUILD_DIR  := obj_dir
LOG        := sim.log
PASS_MSG   := NO ERRORS
LINT_FLAGS := --lint-only --timing
SIM_FLAGS  := --binary --timing --assert -j 0
SIM_ARGS   := +verilator+error+limit+100

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS) | tee $(LOG)
	@if grep -qx "$(PASS_MSG)" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- dv/scope_capture_tb.sv
// testbench for scope_capture_top, ramp and random captures through the wishbone slave
// adc_clk runs at clk/8, adc_data and comp_in change only on adc_clk rises
// the first adc rise after the comparator edge carries sample 0
`default_nettype none
`timescale 1ns/1ps

`include "capture_settings.svh"

module scope_capture_tb;
    import capture_pkg::*;
    import bus_pkg::*;

    typedef struct packed {
        sample_t start;         // ramp start value
        logic    rnd;           // random data instead of the ramp
        logic    abort;         // adc_stable drops halfway
        logic    lock_done;     // host lock held when the bank fills
        logic    exp_switched;
    } cap_row_t;

    localparam int NUM_ROWS   = 4;
    localparam int ACK_LIMIT  = 16;
    localparam int POLL_LIMIT = 8;
    // blocked-trigger phases count as two extra rows
    localparam int WATCHDOG_NS = (NUM_ROWS + 2) * (`CAP_DEPTH + 4) * 8 * 40 * 2 + 8 * 40;

    //   start    rnd   abort lock  switched
    localparam cap_row_t [0:NUM_ROWS-1] ROWS = '{
        '{12'h100, 1'b0, 1'b0, 1'b0, 1'b1},
        '{12'h000, 1'b1, 1'b1, 1'b0, 1'b0},
        '{12'hFE0, 1'b0, 1'b0, 1'b1, 1'b0},  // ramp wraps past 12 bits
        '{12'h000, 1'b1, 1'b0, 1'b0, 1'b1}
    };

    logic              clk = 1'b0;
    logic              rst_n;
    logic              adc_clk = 1'b0;
    sample_t           adc_data;
    logic              adc_stable;
    logic              comp_in;
    logic              wb_cyc;
    logic              wb_stb;
    logic              wb_we;
    logic [BUS_AW-1:0] wb_adr;
    logic [BUS_DW-1:0] wb_dat_w;
    logic [BUS_DW-1:0] wb_dat_r;
    logic              wb_ack;
    logic [2:0]        adc_cnt = 3'd0;
    int                errors = 0;
    int                checks = 0;
    int                seed = 7;
    sample_t           cap_data [`CAP_DEPTH];
    sample_t           shown [`CAP_DEPTH];    // bank the host should see

    scope_capture_top scope_capture_top_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .adc_clk    (adc_clk),
        .adc_data   (adc_data),
        .adc_stable (adc_stable),
        .comp_in    (comp_in),
        .wb_cyc     (wb_cyc),
        .wb_stb     (wb_stb),
        .wb_we      (wb_we),
        .wb_adr     (wb_adr),
        .wb_dat_w   (wb_dat_w),
        .wb_dat_r   (wb_dat_r),
        .wb_ack     (wb_ack)
    );

    always #20 clk = ~clk;

    always @(posedge clk) begin
        adc_cnt <= adc_cnt + 1'b1;
        adc_clk <= (adc_cnt < 3'd4);  // rises when adc_cnt wraps to 0
    end

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired before the capture sequence finished");
        $display("ERRORS FOUND");
        $finish;
    end

    function automatic readout_word_u status_word(input logic switched);
        readout_word_u w;
        w = '0;
        w.status.switched = switched;
        return w;
    endfunction

    task automatic check_sample(input string name, input sample_t got, input sample_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("mismatch %s: got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_word(input string name, input readout_word_u got,
                              input readout_word_u exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("mismatch %s: got %h expected %h", name, got, exp);
        end
    endtask

    // returns on the edge where adc_clk goes high
    task automatic wait_adc_rise();
        do begin
            @(posedge clk);
        end while (adc_cnt != 3'd0);
    endtask

    task automatic wb_transfer(input logic we, input logic [BUS_AW-1:0] addr,
                               input logic [BUS_DW-1:0] wdata, output readout_word_u rdata);
        int waited;
        waited = 0;
        @(posedge clk);
        wb_cyc   <= 1'b1;
        wb_stb   <= 1'b1;
        wb_we    <= we;
        wb_adr   <= addr;
        wb_dat_w <= wdata;
        do begin
            @(posedge clk);
            waited++;
        end while (!wb_ack && waited < ACK_LIMIT);
        rdata = wb_dat_r;
        if (!wb_ack) begin
            errors++;
            $display("no wishbone ack within %0d cycles for address %h", ACK_LIMIT, addr);
        end
        wb_cyc <= 1'b0;
        wb_stb <= 1'b0;
        wb_we  <= 1'b0;
    endtask

    task automatic read_word(input logic [BUS_AW-1:0] addr, output readout_word_u w);
        wb_transfer(1'b0, addr, '0, w);
    endtask

    task automatic write_word(input logic [BUS_AW-1:0] addr, input logic [BUS_DW-1:0] data);
        readout_word_u ignored_rdata;
        wb_transfer(1'b1, addr, data, ignored_rdata);
    endtask

    task automatic poll_status(output readout_word_u w);
        int polls;
        polls = 0;
        do begin
            read_word(STATUS_ADDR, w);
            polls++;
        end while (!w.status.switched && polls < POLL_LIMIT);
    endtask

    task automatic check_bank();
        readout_word_u w;
        for (int i = 0; i < `CAP_DEPTH; i++) begin
            read_word(16'(i), w);
            check_sample($sformatf("wb_dat_r[%0d]", i), w.sample.value, shown[i]);
        end
    endtask

    task automatic run_capture(input cap_row_t row);
        for (int i = 0; i < `CAP_DEPTH; i++) begin
            cap_data[i] = row.rnd ? sample_t'($random(seed)) : sample_t'(row.start + i);
        end
        wait_adc_rise();
        comp_in <= 1'b1;  // trigger edge
        for (int i = 0; i < `CAP_DEPTH; i++) begin
            wait_adc_rise();
            adc_data <= cap_data[i];
            if (i == 1) begin
                comp_in <= 1'b0;
            end
            if (row.abort && i == `CAP_DEPTH / 2) begin
                adc_stable <= 1'b0;
            end
            if (row.lock_done && i == `CAP_DEPTH / 2) begin
                write_word(STATUS_ADDR, 16'h0001);  // fits inside one adc period
            end
        end
        wait_adc_rise();
        adc_stable <= 1'b1;
    endtask

    // comparator edge that must not start a capture
    task automatic blocked_trigger(input logic by_lock);
        readout_word_u w;
        if (by_lock) begin
            write_word(STATUS_ADDR, 16'h0001);
        end
        wait_adc_rise();
        if (!by_lock) begin
            adc_stable <= 1'b0;
        end
        repeat (2) wait_adc_rise();
        comp_in <= 1'b1;
        repeat (2) wait_adc_rise();
        comp_in <= 1'b0;
        repeat (2) wait_adc_rise();
        adc_stable <= 1'b1;
        repeat (`CAP_DEPTH + 4) wait_adc_rise();  // longer than one bank fill
        if (by_lock) begin
            write_word(STATUS_ADDR, 16'h0000);
        end
        poll_status(w);
        check_word(by_lock ? "status, edge under lock" : "status, edge while unstable",
                   w, status_word(1'b0));
    endtask

    initial begin
        readout_word_u w;
        readout_word_u masked;
        readout_word_u all_ones;
        rst_n      = 1'b0;
        adc_data   = '0;
        adc_stable = 1'b1;
        comp_in    = 1'b0;
        wb_cyc     = 1'b0;
        wb_stb     = 1'b0;
        wb_we      = 1'b0;
        wb_adr     = '0;
        wb_dat_w   = '0;
        all_ones   = '1;
        repeat (8) @(posedge clk);
        rst_n <= 1'b1;

        read_word(STATUS_ADDR, w);
        check_word("status after reset", w, status_word(1'b0));
        read_word(16'h0005, w);
        masked = w;
        masked.sample.value = '0;  // bank content unknown, only the pad is defined
        check_word("sample pad after reset", masked, '0);

        for (int r = 0; r < NUM_ROWS; r++) begin
            run_capture(ROWS[r]);
            poll_status(w);
            check_word($sformatf("status row %0d", r), w, status_word(ROWS[r].exp_switched));
            if (ROWS[r].abort) begin
                check_bank();  // previous capture still readable
            end else begin
                if (ROWS[r].lock_done) begin
                    check_bank();
                    write_word(STATUS_ADDR, 16'h0000);
                    poll_status(w);
                    check_word($sformatf("status row %0d after release", r), w,
                               status_word(1'b1));
                end
                shown = cap_data;
                write_word(STATUS_ADDR, 16'h0001);
                read_word(STATUS_ADDR, w);
                check_word($sformatf("status row %0d under lock", r), w, status_word(1'b0));
                check_bank();
                write_word(STATUS_ADDR, 16'h0000);
            end
        end

        blocked_trigger(1'b1);
        blocked_trigger(1'b0);

        read_word(16'h4001, w);
        check_word("unmapped register", w, all_ones);
        read_word(16'(3 * `CAP_DEPTH + 5), w);
        check_sample("wrapped sample address", w.sample.value, shown[5]);

        errors += scope_capture_top_i.sample_writer_i.writer_asserts_i.fail_count;
        errors += scope_capture_top_i.wb_readout_i.readout_asserts_i.fail_count;
        $display("run complete: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- dv/scope_capture_asserts.sv
// handshake and swap rules, bound into the sampler and the wishbone slave
// SAMPLER_SIDE selects the sampler rules, otherwise the wishbone rules run
`default_nettype none
`timescale 1ns/1ps

module scope_capture_asserts #(
    parameter bit SAMPLER_SIDE = 1'b1  // sampler rules, else bus rules
) (
    input wire                              clk,
    input wire                              rst_n,
    input wire                              wb_ack,
    input wire                              read_lock,
    input wire                              wr_en,
    input wire                              bank_sel,
    input wire capture_pkg::sampler_state_t state
);
    import capture_pkg::*;

    int fail_count = 0;  // failed assertions so far

    if (SAMPLER_SIDE) begin : g_sampler
        // banks never swap under the host lock
        swap_unlocked: assert property (@(posedge clk) disable iff (!rst_n)
                                        read_lock |=> $stable(bank_sel))
            else begin
                fail_count++;
                $error("bank_sel changed while read_lock is high");
            end

        // a write belongs to a running capture, never ends it in idle
        write_in_sampling: assert property (@(posedge clk) disable iff (!rst_n)
                                            wr_en |=> state != ST_IDLE)
            else begin
                fail_count++;
                $error("wr_en outside a running capture");
            end
    end else begin : g_bus
        ack_one_cycle: assert property (@(posedge clk) disable iff (!rst_n)
                                        wb_ack |=> !wb_ack)
            else begin
                fail_count++;
                $error("wb_ack high two cycles running");
            end
    end

endmodule

bind sample_writer scope_capture_asserts #(.SAMPLER_SIDE(1'b1)) writer_asserts_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .wb_ack    (1'b0),
    .read_lock (read_lock),
    .wr_en     (wr_en),
    .bank_sel  (bank_sel),
    .state     (state)
);

bind wb_readout scope_capture_asserts #(.SAMPLER_SIDE(1'b0)) readout_asserts_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .wb_ack    (wb_ack),
    .read_lock (read_lock),
    .wr_en     (1'b0),
    .bank_sel  (1'b0),
    .state     (capture_pkg::ST_IDLE)
);

`default_nettype wire

//--- hw/scope_capture_top.sv
// triggered double-buffered adc capture with a wishbone readout
// all inputs synchronous to clk, no synchronisers inside
`default_nettype none
`timescale 1ns/1ps

module scope_capture_top (
    input  wire                        clk,
    input  wire                        rst_n,
    input  wire                        adc_clk,
    input  wire capture_pkg::sample_t  adc_data,
    input  wire                        adc_stable,
    input  wire                        comp_in,
    input  wire                        wb_cyc,
    input  wire                        wb_stb,
    input  wire                        wb_we,
    input  wire [bus_pkg::BUS_AW-1:0]  wb_adr,
    input  wire [bus_pkg::BUS_DW-1:0]  wb_dat_w,
    output logic [bus_pkg::BUS_DW-1:0] wb_dat_r,
    output logic                       wb_ack
);
    import capture_pkg::*;

    logic    wr_en;
    idx_t    wr_idx;
    sample_t wr_data;
    logic    bank_sel;
    logic    swap_pulse;
    logic    read_lock;
    idx_t    rd_idx;
    sample_t rd_data;

    sample_writer sample_writer_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .adc_clk    (adc_clk),
        .adc_data   (adc_data),
        .adc_stable (adc_stable),
        .comp_in    (comp_in),
        .read_lock  (read_lock),
        .wr_en      (wr_en),
        .wr_idx     (wr_idx),
        .wr_data    (wr_data),
        .bank_sel   (bank_sel),
        .swap_pulse (swap_pulse)
    );

    pingpong_ram pingpong_ram_i (
        .clk      (clk),
        .wr_en    (wr_en),
        .wr_idx   (wr_idx),
        .wr_data  (wr_data),
        .bank_sel (bank_sel),
        .rd_idx   (rd_idx),
        .rd_data  (rd_data)
    );

    wb_readout wb_readout_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .wb_cyc     (wb_cyc),
        .wb_stb     (wb_stb),
        .wb_we      (wb_we),
        .wb_adr     (wb_adr),
        .wb_dat_w   (wb_dat_w),
        .swap_pulse (swap_pulse),
        .rd_data    (rd_data),
        .wb_dat_r   (wb_dat_r),
        .wb_ack     (wb_ack),
        .rd_idx     (rd_idx),
        .read_lock  (read_lock)
    );

endmodule

`default_nettype wire

//--- hw/bus_slave/wb_readout.sv
// wishbone classic slave for the capture buffer
// reads ack two clk after the request, writes one clk after
// status: read gives switched flag, write bit 0 sets or drops the lock
// other bit-14 addresses read all ones, writes there are acked and ignored
`default_nettype none
`timescale 1ns/1ps

module wb_readout (
    input  wire                        clk,
    input  wire                        rst_n,
    input  wire                        wb_cyc,
    input  wire                        wb_stb,
    input  wire                        wb_we,
    input  wire [bus_pkg::BUS_AW-1:0]  wb_adr,
    input  wire [bus_pkg::BUS_DW-1:0]  wb_dat_w,
    input  wire                        swap_pulse,
    input  wire capture_pkg::sample_t  rd_data,
    output logic [bus_pkg::BUS_DW-1:0] wb_dat_r,
    output logic                       wb_ack,
    output capture_pkg::idx_t          rd_idx,
    output logic                       read_lock
);
    import capture_pkg::*;
    import bus_pkg::*;

    logic          req;
    logic          busy;  // read waiting on the memory
    logic          hold;  // acked, wait for stb low
    logic          lock_q;
    logic          switched;
    logic          is_status;
    readout_word_u word;

    assign req       = wb_cyc & wb_stb & ~busy & ~hold;
    assign is_status = (wb_adr == STATUS_ADDR);
    assign rd_idx    = wb_adr[IDX_W-1:0];  // high bits dropped, wraps at depth

    always_comb begin
        if (is_status) begin
            word.status = '{pad: '0, switched: switched};
        end else if (wb_adr[REG_SPACE_BIT]) begin
            word = '1;  // unmapped register
        end else begin
            word.sample = '{pad: '0, value: rd_data};
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy      <= 1'b0;
            hold      <= 1'b0;
            wb_ack    <= 1'b0;
            read_lock <= 1'b0;
        end else begin
            wb_ack <= 1'b0;
            if (!wb_stb) begin
                hold <= 1'b0;
            end
            if (busy) begin
                busy   <= 1'b0;
                wb_ack <= 1'b1;
                hold   <= 1'b1;
            end else if (req) begin
                if (wb_we) begin
                    wb_ack <= 1'b1;
                    hold   <= 1'b1;
                    if (is_status) begin
                        read_lock <= wb_dat_w[0];
                    end
                end else begin
                    busy <= 1'b1;  // memory read in flight
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (busy) begin
            wb_dat_r <= word;
        end
    end

    // lock rising edge beats a same-cycle swap
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            lock_q   <= 1'b0;
            switched <= 1'b0;
        end else begin
            lock_q <= read_lock;
            if (read_lock && !lock_q) begin
                switched <= 1'b0;
            end else if (swap_pulse) begin
                switched <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

//--- hw/pingpong/pingpong_ram.sv
// two sample banks, one written and the other read by the host
// no reset on the arrays so they can map to block RAM
// read data is registered, valid one clk after rd_idx
`default_nettype none
`timescale 1ns/1ps

`include "capture_settings.svh"

module pingpong_ram (
    input  wire                  clk,
    input  wire                  wr_en,
    input  wire capture_pkg::idx_t    wr_idx,
    input  wire capture_pkg::sample_t wr_data,
    input  wire                  bank_sel,
    input  wire capture_pkg::idx_t    rd_idx,
    output capture_pkg::sample_t rd_data
);
    import capture_pkg::*;

    sample_t bank0 [`CAP_DEPTH];
    sample_t bank1 [`CAP_DEPTH];
    sample_t rd_bank0;
    sample_t rd_bank1;
    logic    rd_sel_q;  // bank_sel at read time

    // write port follows bank_sel
    always_ff @(posedge clk) begin
        if (wr_en && !bank_sel) begin
            bank0[wr_idx] <= wr_data;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en && bank_sel) begin
            bank1[wr_idx] <= wr_data;
        end
    end

    // both banks read every cycle, the mux picks the idle one
    always_ff @(posedge clk) begin
        rd_bank0 <= bank0[rd_idx];
        rd_bank1 <= bank1[rd_idx];
        rd_sel_q <= bank_sel;
    end

    assign rd_data = rd_sel_q ? rd_bank0 : rd_bank1;  // host sees the other bank

endmodule

`default_nettype wire

//--- hw/sampler/sample_writer.sv
// trigger and bank fill for the capture path
// adc_clk, adc_data and comp_in must already be synchronous to clk
// adc_data has to stay put for a full adc_clk period
`default_nettype none
`timescale 1ns/1ps

`include "capture_settings.svh"

module sample_writer (
    input  wire                  clk,
    input  wire                  rst_n,
    input  wire                  adc_clk,
    input  wire capture_pkg::sample_t adc_data,
    input  wire                  adc_stable,
    input  wire                  comp_in,
    input  wire                  read_lock,
    output logic                 wr_en,
    output capture_pkg::idx_t    wr_idx,
    output capture_pkg::sample_t wr_data,
    output logic                 bank_sel,
    output logic                 swap_pulse
);
    import capture_pkg::*;

    sampler_state_t state;
    idx_t           idx;
    logic           adc_clk_q;
    logic           adc_edge;   // one clk after adc_clk rose
    logic           comp_q;     // comparator at the previous adc edge
    logic           comp_rise;
    logic           trigger;

    assign comp_rise = adc_edge & comp_in & ~comp_q;
    assign trigger   = (state == ST_IDLE) & comp_rise & adc_stable & ~read_lock;

    // one sample per detected adc edge while the bank fills
    assign wr_en      = (state == ST_SAMPLING) & adc_edge & adc_stable;
    assign wr_idx     = idx;
    assign wr_data    = adc_data;
    assign swap_pulse = (state == ST_SWAP) & ~read_lock;  // host lock stalls the swap

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            adc_clk_q <= 1'b0;
            adc_edge  <= 1'b0;
            comp_q    <= 1'b0;
        end else begin
            adc_clk_q <= adc_clk;
            adc_edge  <= adc_clk & ~adc_clk_q;
            if (adc_edge) begin
                comp_q <= comp_in;  // comparator only tracked at adc rate
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= ST_IDLE;
            idx      <= '0;
            bank_sel <= 1'b0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (trigger) begin
                        state <= ST_SAMPLING;
                        idx   <= '0;
                    end
                end
                ST_SAMPLING: begin
                    if (!adc_stable) begin
                        state <= ST_IDLE;  // abort, bank stays the write bank
                    end else if (wr_en) begin
                        idx <= idx + 1'b1;
                        if (idx == idx_t'(`CAP_DEPTH - 1)) begin
                            state <= ST_SWAP;
                        end
                    end
                end
                ST_SWAP: begin
                    if (swap_pulse) begin
                        bank_sel <= ~bank_sel;
                        state    <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- common/bus_pkg.sv
// host bus widths, register map and the 16-bit readout word
// sample view pads the sample with zeros up to the bus width
`default_nettype none

`include "capture_settings.svh"

package bus_pkg;

    localparam int BUS_AW = 16;
    localparam int BUS_DW = 16;

    localparam logic [BUS_AW-1:0] STATUS_ADDR = `CAP_STATUS_ADDR;
    localparam int REG_SPACE_BIT = 14;  // set for registers, clear for samples

    typedef struct packed {
        logic [BUS_DW-`CAP_SAMPLE_W-1:0] pad;
        capture_pkg::sample_t            value;
    } sample_view_t;

    typedef struct packed {
        logic [BUS_DW-2:0] pad;
        logic              switched;  // a new bank is ready
    } status_view_t;

    // same read word, decoded by the address it came from
    typedef union packed {
        sample_view_t sample;
        status_view_t status;
    } readout_word_u;

endpackage

`default_nettype wire

//--- common/capture_pkg.sv
// types of the capture path: samples, bank indices, sampler states
// index width follows the bank depth from the settings header
`default_nettype none

`include "capture_settings.svh"

package capture_pkg;

    localparam int IDX_W = $clog2(`CAP_DEPTH);

    // one adc conversion result
    typedef logic [`CAP_SAMPLE_W-1:0] sample_t;

    // position inside one bank
    typedef logic [IDX_W-1:0] idx_t;

    typedef enum logic [1:0] {
        ST_IDLE,      // armed, waiting for trigger
        ST_SAMPLING,  // filling the write bank
        ST_SWAP       // bank full, waiting for lock release
    } sampler_state_t;

endpackage

`default_nettype wire

//--- common/capture_settings.svh
// capture build settings, shared by packages and RTL
// depth must be a power of two, 4096 at most (12 sample address bits)
// status address must have bit 14 set, sample space is bit 14 clear
`ifndef CAPTURE_SETTINGS_SVH
`define CAPTURE_SETTINGS_SVH

// adc sample width in bits
`define CAP_SAMPLE_W 12

// samples per bank, kept small for short simulations
`define CAP_DEPTH 64

// host status / lock register
`define CAP_STATUS_ADDR 16'h4000

`endif
